//--- fpa_adder.f
fpa_pkg.sv
fpa_classify.sv
fpa_align_add.sv
fpa_normalize.sv
fpa_special.sv
fpa_adder.sv
tb_clock_gen.sv
tb_fpa_adder.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_fpa_adder
FILELIST  = fpa_adder.f
PASS_MSG  = Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^$(PASS_MSG)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- tb_fpa_adder.sv
// Directed testbench for the pipelined binary32 adder
// Reset and strobe, exact sums, rounding, specials, range limits
// Back-to-back streaming with a commutativity check
// Compare tasks for result words, valid strobe and pulse counts
// Cycle counter ends a stalled run

`timescale 1ns/1ps

module tb_fpa_adder;
	import fpa_pkg::*;

	// ====================================================================
	// Run limits
	// ====================================================================

	localparam int RESET_CYCLES = 16;
	localparam int ITEM_COUNT   = 60;    // Directed and streaming items rounded up
	localparam int ITEM_CYCLES  = 8;     // Issue, latency and drain per item
	localparam int CYCLE_LIMIT  = RESET_CYCLES + ITEM_COUNT * ITEM_CYCLES + 104;
	localparam int STREAM_PAIRS = 20;

	logic  clk;
	logic  arst_n;
	logic  in_valid;
	fp32_u in_a;
	fp32_u in_b;
	logic  out_valid;
	fp32_u out_result;
	int    cycle_cnt;
	int    seed;
	int    valid_pulses;     // o_valid pulses seen by the monitor
	fp32_u captured[$];      // Results in arrival order

	tb_clock_gen u_clock_gen (.o_clk(clk), .o_arst_n(arst_n));

	fpa_adder fpa_adder_inst (
		.i_clk    (clk),
		.i_arst_n (arst_n),
		.i_valid  (in_valid),
		.i_a      (in_a),
		.i_b      (in_b),
		.o_valid  (out_valid),
		.o_result (out_result)
	);

	// ====================================================================
	// Failure reporting and compare tasks
	// ====================================================================

	task automatic halt_with_failure(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_result(input string name, input fp32_u expected, input fp32_u actual);
		if (actual.raw !== expected.raw) begin
			halt_with_failure($sformatf("FAILED %s: expected %08h, actual %08h",
				name, expected.raw, actual.raw));
		end
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			halt_with_failure($sformatf("FAILED %s: expected %b, actual %b",
				name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			halt_with_failure($sformatf("FAILED %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	// One item through the pipe and its check two rising edges later
	task automatic add_and_check(input string name, input fp32_u a, input fp32_u b,
		input fp32_u expected);
		@(negedge clk);
		in_a     = a;
		in_b     = b;
		in_valid = 1'b1;
		@(negedge clk);
		in_valid = 1'b0;
		check_valid({name, " (early)"}, 1'b0, out_valid);   // Pipe was empty
		@(negedge clk);
		check_valid(name, 1'b1, out_valid);
		check_result(name, expected, out_result);
	endtask

	// Normal operand with its exponent well inside range
	task automatic make_random_normal(output fp32_u v);
		logic [31:0] bits;
		bits         = $random(seed);
		v.raw        = bits;
		v.fields.exp = 8'd64 + {1'b0, bits[30:24]};   // 64 to 191
	endtask

	// ====================================================================
	// Directed tests
	// ====================================================================

	task automatic test_reset_and_strobe();
		while (arst_n !== 1'b1) begin
			@(negedge clk);
			check_valid("valid low in reset", 1'b0, out_valid);
		end
		repeat (3) begin
			@(negedge clk);
			check_valid("valid low after reset", 1'b0, out_valid);
		end
		in_a     = 32'h3F80_0000;   // Single strobe
		in_b     = 32'h4000_0000;
		in_valid = 1'b1;
		@(negedge clk);
		in_valid = 1'b0;
		check_valid("strobe after one edge", 1'b0, out_valid);
		@(negedge clk);
		check_valid("strobe after two edges", 1'b1, out_valid);
		check_result("strobe result", 32'h4040_0000, out_result);
		repeat (2) begin
			@(negedge clk);
			check_valid("strobe single pulse", 1'b0, out_valid);
		end
	endtask

	task automatic test_exact_sums();
		add_and_check("1 + 2", 32'h3F80_0000, 32'h4000_0000, 32'h4040_0000);
		add_and_check("1.5 - 0.5", 32'h3FC0_0000, 32'hBF00_0000, 32'h3F80_0000);
		add_and_check("3 - 2", 32'h4040_0000, 32'hC000_0000, 32'h3F80_0000);
	endtask

	task automatic test_rounding();
		add_and_check("tie to even", 32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000);
		add_and_check("above half", 32'h3F80_0000, 32'h3440_0000, 32'h3F80_0002);
		add_and_check("tie from odd", 32'h3F80_0001, 32'h3380_0000, 32'h3F80_0002);
	endtask

	task automatic test_specials();
		add_and_check("nan on a", 32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000);
		add_and_check("nan on b", 32'h3F80_0000, 32'hFFC0_0000, 32'h7FC0_0000);
		add_and_check("inf minus inf", 32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000);
		add_and_check("inf plus one", 32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000);
		add_and_check("neg zeros", 32'h8000_0000, 32'h8000_0000, 32'h8000_0000);
		add_and_check("mixed zeros", 32'h0000_0000, 32'h8000_0000, 32'h0000_0000);
		add_and_check("x minus x", 32'h3F80_0000, 32'hBF80_0000, 32'h0000_0000);
		add_and_check("subnormal flush", 32'h0000_0001, 32'h3F80_0000, 32'h3F80_0000);
	endtask

	task automatic test_range_limits();
		add_and_check("overflow", 32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000);
		add_and_check("underflow", 32'h0080_0001, 32'h8080_0000, 32'h0000_0000);
	endtask

	// Each pair issued as (a, b) then (b, a) with no gaps
	task automatic test_streaming();
		fp32_u a;
		fp32_u b;
		string name;
		@(negedge clk);
		valid_pulses = 0;   // Pipe is idle here
		captured.delete();
		for (int i = 0; i < STREAM_PAIRS; i++) begin
			make_random_normal(a);
			make_random_normal(b);
			in_a     = a;
			in_b     = b;
			in_valid = 1'b1;
			@(negedge clk);
			in_a = b;
			in_b = a;
			@(negedge clk);
		end
		in_valid = 1'b0;
		while (captured.size() < 2 * STREAM_PAIRS) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);   // Room for a stray pulse
		check_count("streaming pulse count", 2 * STREAM_PAIRS, valid_pulses);
		for (int i = 0; i < STREAM_PAIRS; i++) begin
			name = $sformatf("streaming pair %0d", i);
			check_result(name, captured[2*i], captured[2*i+1]);
		end
	endtask

	// ====================================================================
	// Monitor, timeout and sequence
	// ====================================================================

	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			valid_pulses = valid_pulses + 1;
			captured.push_back(out_result);
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			halt_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
				CYCLE_LIMIT));
		end
	end

	initial begin
		seed         = 7;
		cycle_cnt    = 0;
		valid_pulses = 0;
		in_valid     = 1'b0;
		in_a         = '0;
		in_b         = '0;
		test_reset_and_strobe();
		test_exact_sums();
		test_rounding();
		test_specials();
		test_range_limits();
		test_streaming();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset source
// 8 ns free-running clock
// Active-low asynchronous reset held for 16 cycles

`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_arst_n
);
	localparam real HALF_PERIOD  = 4.0;   // 8 ns period
	localparam int  RESET_CYCLES = 16;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	initial begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_arst_n = 1'b1;   // Released midway between rising edges
	end

endmodule

//--- fpa_adder.sv
// Two-stage pipelined binary32 adder
// Stage 1 classifies, aligns and adds into the stage register
// Stage 2 normalizes, rounds and selects special results
// Valid strobe follows the data with a fixed latency of two clocks

`timescale 1ns/1ps

module fpa_adder (
	input  logic           i_clk,
	input  logic           i_arst_n,
	input  logic           i_valid,
	input  fpa_pkg::fp32_u i_a,
	input  fpa_pkg::fp32_u i_b,
	output logic           o_valid,
	output fpa_pkg::fp32_u o_result
);
	import fpa_pkg::*;

	fp_unpacked_t     unp_a;
	fp_unpacked_t     unp_b;
	fp_class_t        class_a;
	fp_class_t        class_b;
	logic             add_sign;
	logic [EXP_W-1:0] add_exp_big;
	logic             add_eff_sub;
	logic [SUM_W-1:0] add_sum;
	add_stage_t       stage_d;
	add_stage_t       stage_q;
	logic             stage_vld;     // Stage register holds a live item
	fp32_u            normal_res;
	fp32_u            final_res;

	// ====================================================================
	// Stage 1
	// ====================================================================

	fpa_classify u_classify_a (.i_op(i_a), .o_unp(unp_a), .o_class(class_a));
	fpa_classify u_classify_b (.i_op(i_b), .o_unp(unp_b), .o_class(class_b));

	fpa_align_add u_align_add (
		.i_a       (unp_a),
		.i_b       (unp_b),
		.o_sign    (add_sign),
		.o_exp_big (add_exp_big),
		.o_eff_sub (add_eff_sub),
		.o_sum     (add_sum)
	);

	always_comb begin
		stage_d.sign    = add_sign;
		stage_d.exp_big = add_exp_big;
		stage_d.eff_sub = add_eff_sub;
		stage_d.sum     = add_sum;
		stage_d.class_a = class_a;       // Carried for special selection
		stage_d.class_b = class_b;
		stage_d.op_a    = i_a;
		stage_d.op_b    = i_b;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			stage_vld <= 1'b0;
			stage_q   <= '0;
		end else begin
			stage_vld <= i_valid;
			if (i_valid) begin
				stage_q <= stage_d;      // Data held while idle
			end
		end
	end

	// ====================================================================
	// Stage 2
	// ====================================================================

	fpa_normalize u_normalize (.i_stage(stage_q), .o_result(normal_res));

	fpa_special u_special (
		.i_class_a (stage_q.class_a),
		.i_class_b (stage_q.class_b),
		.i_op_a    (stage_q.op_a),
		.i_op_b    (stage_q.op_b),
		.i_normal  (normal_res),
		.o_result  (final_res)
	);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid  <= 1'b0;
			o_result <= '0;
		end else begin
			o_valid <= stage_vld;
			if (stage_vld) begin
				o_result <= final_res;
			end
		end
	end

endmodule

//--- fpa_special.sv
// Special-case result selection
// NaN, opposite infinities, infinity, zero operands
// Equal magnitudes of opposite sign
// Falls back to the normal datapath result

`timescale 1ns/1ps

module fpa_special (
	input  fpa_pkg::fp_class_t i_class_a,
	input  fpa_pkg::fp_class_t i_class_b,
	input  fpa_pkg::fp32_u     i_op_a,
	input  fpa_pkg::fp32_u     i_op_b,
	input  fpa_pkg::fp32_u     i_normal,
	output fpa_pkg::fp32_u     o_result
);
	import fpa_pkg::*;

	logic sign_a;
	logic sign_b;

	assign sign_a = i_op_a.fields.sign;
	assign sign_b = i_op_b.fields.sign;

	// Priority order top to bottom
	always_comb begin
		if (i_class_a.is_nan || i_class_b.is_nan) begin
			o_result.raw = CANON_QNAN;
		end else if (i_class_a.is_inf && i_class_b.is_inf && (sign_a ^ sign_b)) begin
			o_result.raw = CANON_QNAN;                        // Inf minus inf
		end else if (i_class_a.is_inf) begin
			o_result = i_op_a;
		end else if (i_class_b.is_inf) begin
			o_result = i_op_b;
		end else if (i_class_a.is_zero && i_class_b.is_zero) begin
			o_result.raw = {sign_a & sign_b, {(WORD_W-1){1'b0}}};  // -0 only if both
		end else if (i_class_a.is_zero) begin
			o_result = i_op_b;
		end else if (i_class_b.is_zero) begin
			o_result = i_op_a;
		end else if ((i_op_a.raw[WORD_W-2:0] == i_op_b.raw[WORD_W-2:0]) && (sign_a ^ sign_b)) begin
			o_result.raw = '0;                                // x + (-x) is +0
		end else begin
			o_result = i_normal;
		end
	end

endmodule

//--- fpa_normalize.sv
// Normalization of the registered significand sum
// Leading zero count and left shift, or one right shift on carry out
// Round to nearest even from guard, round and sticky bits
// Exponent underflow to signed zero and overflow to signed infinity

`timescale 1ns/1ps

module fpa_normalize (
	input  fpa_pkg::add_stage_t i_stage,
	output fpa_pkg::fp32_u      o_result
);
	import fpa_pkg::*;

	localparam int LZ_W = $clog2(SUM_W);

	logic [LZ_W-1:0]         lz;           // Leading zeros below the carry bit
	logic [SUM_W-2:0]        norm;         // Hidden bit on top, GRS at the bottom
	logic signed [EXP_W+1:0] exp_n;        // Exponent after normalizing
	logic signed [EXP_W+1:0] exp_r;        // Exponent after rounding
	logic                    lsb_bit;
	logic                    guard_bit;
	logic                    round_bit;
	logic                    sticky_bit;
	logic                    round_inc;
	logic [MANT_W:0]         rounded;      // Extra bit catches the rounding carry
	logic [MANT_W-1:0]       mant_r;
	logic [EXP_W-1:0]        res_exp;
	logic [FRAC_W-1:0]       res_frac;

	// Leading zeros of the sum without its carry bit
	function automatic logic [LZ_W-1:0] count_lz(input logic [SUM_W-2:0] v);
		logic [LZ_W-1:0] n;
		logic            found;
		n     = '0;
		found = 1'b0;
		for (int i = SUM_W - 2; i >= 0; i--) begin
			if (!found) begin
				if (v[i]) begin
					found = 1'b1;
				end else begin
					n = n + 1'b1;
				end
			end
		end
		return n;
	endfunction

	assign lz = count_lz(i_stage.sum[SUM_W-2:0]);

	// ====================================================================
	// Normalize
	// ====================================================================

	always_comb begin
		if (i_stage.sum[SUM_W-1]) begin
			// On carry out bit 0 folds into sticky
			norm  = {i_stage.sum[SUM_W-1:2], i_stage.sum[1] | i_stage.sum[0]};
			exp_n = $signed({2'b00, i_stage.exp_big}) + 10'sd1;
		end else begin
			norm  = i_stage.sum[SUM_W-2:0] << lz;
			exp_n = $signed({2'b00, i_stage.exp_big}) - $signed({5'b00000, lz});
		end
	end

	// ====================================================================
	// Round to nearest even
	// ====================================================================

	assign lsb_bit    = norm[GUARD_W];
	assign guard_bit  = norm[GUARD_W-1];
	assign round_bit  = norm[GUARD_W-2];
	assign sticky_bit = norm[0];
	assign round_inc  = guard_bit & (round_bit | sticky_bit | lsb_bit);

	assign rounded = {1'b0, norm[SUM_W-2:GUARD_W]} + (MANT_W+1)'(round_inc);

	// Rounding carry renormalizes by one place
	assign mant_r = rounded[MANT_W] ? rounded[MANT_W:1] : rounded[MANT_W-1:0];
	assign exp_r  = exp_n + $signed({{(EXP_W+1){1'b0}}, rounded[MANT_W]});

	// ====================================================================
	// Range limits
	// ====================================================================

	always_comb begin
		if (~|i_stage.sum || exp_r <= 0) begin
			res_exp  = '0;                       // Signed zero without gradual underflow
			res_frac = '0;
		end else if (exp_r >= $signed({2'b00, EXP_MAX})) begin
			res_exp  = EXP_MAX;                  // Signed infinity
			res_frac = '0;
		end else begin
			res_exp  = exp_r[EXP_W-1:0];
			res_frac = mant_r[FRAC_W-1:0];       // Hidden bit dropped
		end
	end

	assign o_result.fields = {i_stage.sign, res_exp, res_frac};

endmodule

//--- fpa_align_add.sv
// Exponent compare and operand swap
// Right alignment of the smaller significand with sticky collection
// Significand add or subtract by effective operation
// Result sign from the larger magnitude, +0 on exact cancellation

`timescale 1ns/1ps

module fpa_align_add (
	input  fpa_pkg::fp_unpacked_t          i_a,
	input  fpa_pkg::fp_unpacked_t          i_b,
	output logic                           o_sign,
	output logic [fpa_pkg::EXP_W-1:0]      o_exp_big,
	output logic                           o_eff_sub,
	output logic [fpa_pkg::SUM_W-1:0]      o_sum
);
	import fpa_pkg::*;

	fp_unpacked_t       op_big;      // Larger magnitude
	fp_unpacked_t       op_small;    // Operand to be shifted
	logic               a_ge_b;
	logic [EXP_W-1:0]   exp_diff;
	logic [EXP_W-1:0]   shift_amt;   // Saturated shift distance
	logic [SUM_W-1:0]   big_ext;
	logic [SUM_W-1:0]   small_ext;
	logic [SUM_W-1:0]   small_al;    // Aligned with sticky folded into bit 0
	logic [2*SUM_W-1:0] shift_win;   // Upper half kept, lower half lost
	logic               sticky;

	// ====================================================================
	// Compare and swap
	// ====================================================================

	// Exponent first and significand on a tie
	assign a_ge_b   = {i_a.exp, i_a.mant} >= {i_b.exp, i_b.mant};
	assign op_big   = a_ge_b ? i_a : i_b;
	assign op_small = a_ge_b ? i_b : i_a;

	assign exp_diff  = op_big.exp - op_small.exp;   // Never negative after swap
	assign shift_amt = (exp_diff > EXP_W'(SUM_W)) ? EXP_W'(SUM_W) : exp_diff;

	// ====================================================================
	// Alignment
	// ====================================================================

	// Carry slot on top, guard bits below
	assign big_ext   = {1'b0, op_big.mant, {GUARD_W{1'b0}}};
	assign small_ext = {1'b0, op_small.mant, {GUARD_W{1'b0}}};

	assign shift_win = {small_ext, {SUM_W{1'b0}}} >> shift_amt;
	assign sticky    = |shift_win[SUM_W-1:0];   // Everything shifted out
	assign small_al  = {shift_win[2*SUM_W-1:SUM_W+1], shift_win[SUM_W] | sticky};

	// ====================================================================
	// Add or subtract
	// ====================================================================

	assign o_eff_sub = i_a.sign ^ i_b.sign;

	// Big minus small cannot go negative
	assign o_sum = o_eff_sub ? (big_ext - small_al) : (big_ext + small_al);

	assign o_exp_big = op_big.exp;

	// Exact cancellation gives +0
	assign o_sign = (o_eff_sub && ~|o_sum) ? 1'b0 : op_big.sign;

endmodule

//--- fpa_classify.sv
// Operand classifier for one binary32 input
// Zero, infinity and NaN flags
// Unpacked sign, exponent and significand with hidden bit
// Subnormals are flushed to a zero of their own sign

`timescale 1ns/1ps

module fpa_classify (
	input  fpa_pkg::fp32_u        i_op,
	output fpa_pkg::fp_unpacked_t o_unp,
	output fpa_pkg::fp_class_t    o_class
);
	import fpa_pkg::*;

	logic exp_zero;   // Exponent all zero
	logic exp_ones;   // Exponent all ones
	logic frac_nz;    // Any fraction bit set

	assign exp_zero = ~|i_op.fields.exp;
	assign exp_ones = &i_op.fields.exp;
	assign frac_nz  = |i_op.fields.frac;

	// Subnormal counts as zero
	assign o_class.is_zero = exp_zero;
	assign o_class.is_inf  = exp_ones & ~frac_nz;
	assign o_class.is_nan  = exp_ones & frac_nz;

	assign o_unp.sign = i_op.fields.sign;   // Sign kept even when flushed
	assign o_unp.exp  = i_op.fields.exp;

	// Flushed operand contributes nothing to the sum
	assign o_unp.mant = exp_zero ? '0 : {1'b1, i_op.fields.frac};

endmodule

//--- fpa_pkg.sv
// Shared definitions for the pipelined binary32 adder
// Field widths and special constants
// Word union read as raw bits or as sign, exponent and fraction
// Operand class flags and unpacked operand
// Stage struct held between the add and normalize stages

package fpa_pkg;

	// ====================================================================
	// Widths and constants
	// ====================================================================

	localparam int WORD_W  = 32;                         // binary32 word
	localparam int EXP_W   = 8;                          // Biased exponent
	localparam int FRAC_W  = 23;                         // Stored fraction
	localparam int MANT_W  = FRAC_W + 1;                 // With hidden bit
	localparam int GUARD_W = 3;                          // Guard, round, sticky
	localparam int SUM_W   = MANT_W + GUARD_W + 1;       // Plus carry out

	localparam logic [EXP_W-1:0]  EXP_MAX    = '1;       // Inf and NaN exponent
	localparam logic [WORD_W-1:0] CANON_QNAN = 32'h7FC0_0000;

	// ====================================================================
	// Types
	// ====================================================================

	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [FRAC_W-1:0] frac;
	} fp32_fields_t;

	// Same word seen as raw bits or as its fields
	typedef union packed {
		logic [WORD_W-1:0] raw;
		fp32_fields_t      fields;
	} fp32_u;

	typedef struct packed {
		logic is_zero;   // True zero or flushed subnormal
		logic is_inf;
		logic is_nan;
	} fp_class_t;

	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [MANT_W-1:0] mant;  // Hidden bit at the top
	} fp_unpacked_t;

	// Registered between add and normalize
	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp_big;
		logic             eff_sub;
		logic [SUM_W-1:0] sum;
		fp_class_t        class_a;
		fp_class_t        class_b;
		fp32_u            op_a;
		fp32_u            op_b;
	} add_stage_t;

endpackage
